/* verilog/icache_pkg.sv */
// Cache geometry and shared port types, imported by every instruction cache RTL file
package icache_pkg;

  // ----------------------------------------
  // Geometry
  // ----------------------------------------
  localparam int XLEN        = 32;                         // Fetch and parcel width
  localparam int BLOCK_BYTES = 16;                         // Bytes per line
  localparam int BURST_LEN   = BLOCK_BYTES / (XLEN / 8);   // Words per line = refill beats
  localparam int OFFS_BITS   = $clog2(BURST_LEN);          // Word within line
  localparam int BYTE_BITS   = $clog2(XLEN / 8);           // Byte within word
  localparam int IDX_BITS    = 6;
  localparam int SETS        = 2 ** IDX_BITS;
  localparam int TAG_BITS    = XLEN - IDX_BITS - OFFS_BITS - BYTE_BITS;

  // ----------------------------------------
  // Address views
  // ----------------------------------------
  typedef struct packed {
    logic [TAG_BITS-1:0]  tag;
    logic [IDX_BITS-1:0]  idx;
    logic [OFFS_BITS-1:0] offs;
    logic [BYTE_BITS-1:0] bofs;   // Always word aligned, ignored
  } fetch_fields_t;

  // Same fetch word, raw for storage or split for lookup
  typedef union packed {
    logic [XLEN-1:0] raw;
    fetch_fields_t   f;
  } fetch_adr_u;

  // Line address as sent to the bus
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic [IDX_BITS-1:0] idx;
  } line_adr_t;

  typedef struct packed {
    logic       valid;
    fetch_adr_u adr;
  } stage_t;

  typedef logic [BURST_LEN-1:0][XLEN-1:0] line_t;   // Word 0 in the low bits

  // ----------------------------------------
  // Refill, bus and CPU response
  // ----------------------------------------
  typedef struct packed {
    logic                done;   // One cycle strobe
    logic                err;    // Some beat failed
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    line_t               line;
  } fill_t;

  typedef struct packed {
    logic      stb;
    line_adr_t adr;
  } biu_req_t;

  typedef struct packed {
    logic            stb_ack;   // Request taken
    logic            ack;       // Beat valid
    logic            err;
    logic [XLEN-1:0] q;
  } biu_rsp_t;

  typedef struct packed {
    logic            valid;
    logic            err;
    logic [XLEN-1:0] data;
  } parcel_t;

endpackage

/* verilog/icache_pipe.sv */
// Setup and tag stage registers of the fetch pipeline, held on stall and killed on flush
module icache_pipe (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   req_i,
  input  icache_pkg::fetch_adr_u adr_i,

  input  logic                   stall_i,   // Hold both stages
  input  logic                   flush_i,   // Drops both stages over stall

  output icache_pkg::stage_t     setup_o,
  output icache_pkg::stage_t     tag_o
);
  import icache_pkg::*;

  logic       setup_vld_q;
  logic       tag_vld_q;
  fetch_adr_u setup_adr_q;
  fetch_adr_u tag_adr_q;

  // ----------------------------------------
  // Valid bits
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      setup_vld_q <= 1'b0;
      tag_vld_q   <= 1'b0;
    end else if (flush_i) begin
      setup_vld_q <= 1'b0;   // Kill whatever is in flight
      tag_vld_q   <= 1'b0;
    end else if (!stall_i) begin
      setup_vld_q <= req_i;         // Accepted request
      tag_vld_q   <= setup_vld_q;
    end
  end

  // Addresses move along with the valid bits
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      setup_adr_q.raw <= adr_i.raw;   // Kept raw, split on use
      tag_adr_q       <= setup_adr_q;
    end
  end

  assign setup_o.valid = setup_vld_q;
  assign setup_o.adr   = setup_adr_q;
  assign tag_o.valid   = tag_vld_q;
  assign tag_o.adr     = tag_adr_q;

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // The setup stage takes nothing while stalled, so the CPU keeps the waiting request
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && stall_i && !flush_i |=> req_i && $stable(adr_i.raw));

endmodule

/* verilog/icache_memory.sv */
// Tag, valid and data arrays with registered read, hit compare, refill write and flush
module icache_memory #(
  parameter int WAYS = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               stall_i,
  input  icache_pkg::stage_t setup_i,        // Read index source when advancing
  input  icache_pkg::stage_t tag_i,          // Compare source, read index under stall

  input  icache_pkg::fill_t  fill_i,
  input  logic [WAYS-1:0]    fill_way_i,     // One-hot victim
  input  logic               invalidate_i,   // Clear every valid bit

  output logic               hit_o,
  output icache_pkg::line_t  line_o
);
  import icache_pkg::*;

  // Arrays
  logic [TAG_BITS-1:0]       tag_mem  [WAYS][SETS];
  line_t                     data_mem [WAYS][SETS];
  logic [WAYS-1:0][SETS-1:0] valid_q;

  // Read side
  logic [IDX_BITS-1:0] rd_idx;
  logic [TAG_BITS-1:0] rd_tag_q  [WAYS];
  line_t               rd_line_q [WAYS];
  logic [WAYS-1:0]     rd_valid_q;
  logic [WAYS-1:0]     way_hit;
  logic                fill_we;

  assign fill_we = fill_i.done & ~fill_i.err;   // Bad line never lands
  // Reread the waiting entry while stalled so it sees fills and flushes
  assign rd_idx  = stall_i ? tag_i.adr.f.idx : setup_i.adr.f.idx;

  // ----------------------------------------
  // Refill write
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < WAYS; w++) begin
      if (fill_we && fill_way_i[w]) begin
        tag_mem[w][fill_i.idx]  <= fill_i.tag;
        data_mem[w][fill_i.idx] <= fill_i.line;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (invalidate_i) begin
      valid_q <= '0;                    // Whole cache in one edge
    end else if (fill_we) begin
      for (int w = 0; w < WAYS; w++) begin
        if (fill_way_i[w]) begin
          valid_q[w][fill_i.idx] <= 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Read register
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < WAYS; w++) begin
      rd_tag_q[w]  <= tag_mem[w][rd_idx];
      rd_line_q[w] <= data_mem[w][rd_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= '0;
    end else if (invalidate_i) begin
      rd_valid_q <= '0;                 // Else a stale hit right after flush
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        rd_valid_q[w] <= valid_q[w][rd_idx];
      end
    end
  end

  // Hit compare and way mux
  always_comb begin
    line_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      way_hit[w] = tag_i.valid & rd_valid_q[w] & (rd_tag_q[w] == tag_i.adr.f.tag);
      if (way_hit[w]) begin
        line_o = line_o | rd_line_q[w];
      end
    end
  end

  assign hit_o = |way_hit;

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Refill only on miss, so a line lives in one way at most
  a_one_way_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(way_hit));

  a_fill_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_we |-> $onehot(fill_way_i));

endmodule

/* verilog/icache_ctrl.sv */
// Front end FSM of the instruction cache, handles stall, refill, invalidate and parcel output
module icache_ctrl #(
  parameter int WAYS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  flush_i,
  input  logic                  cache_flush_i,
  input  icache_pkg::stage_t    tag_i,
  input  logic                  hit_i,
  input  icache_pkg::line_t     line_i,
  input  icache_pkg::fill_t     fill_i,

  output logic                  stall_o,
  output logic                  refill_start_o,
  output icache_pkg::line_adr_t refill_adr_o,
  output logic [WAYS-1:0]       fill_way_o,
  output logic                  invalidate_o,
  output icache_pkg::parcel_t   parcel_o
);
  import icache_pkg::*;

  localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,      // Hits stream
    ST_REFILL,    // Waiting on the bus
    ST_DELIVER,   // Word from the fresh line
    ST_INVAL      // Clearing valid bits
  } state_e;

  state_e               state_q;
  state_e               state_d;
  logic [6:0]           lfsr_q;       // Free running victim source
  logic [WAY_BITS-1:0]  victim;
  logic [WAYS-1:0]      fill_way_q;
  logic                 cflush_q;     // Invalidate pending
  logic                 miss;
  logic [OFFS_BITS-1:0] offs;

  assign offs   = tag_i.adr.f.offs;
  assign miss   = tag_i.valid & ~hit_i & ~flush_i;   // Killed entries never refill
  assign victim = (WAYS > 1) ? lfsr_q[WAY_BITS-1:0] : '0;

  // ----------------------------------------
  // Next state, stall, refill start
  // ----------------------------------------
  always_comb begin
    state_d        = state_q;
    stall_o        = 1'b0;
    refill_start_o = 1'b0;
    case (state_q)
      ST_IDLE: begin
        stall_o = miss;                     // Hold the missing entry
        if (cflush_q) begin
          state_d = ST_INVAL;               // Flush first, miss retried after
        end else if (miss) begin
          refill_start_o = 1'b1;
          state_d        = ST_REFILL;
        end
      end
      ST_REFILL: begin
        stall_o = 1'b1;
        if (fill_i.done) begin
          state_d = ST_DELIVER;
        end
      end
      ST_DELIVER: state_d = ST_IDLE;       // Stall already low here
      ST_INVAL: begin
        stall_o = 1'b1;                     // Single stall cycle
        state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      cflush_q   <= 1'b0;
      lfsr_q     <= '0;
      fill_way_q <= '0;
    end else begin
      state_q <= state_d;
      if (cache_flush_i) begin
        cflush_q <= 1'b1;
      end else if (state_q == ST_INVAL) begin
        cflush_q <= 1'b0;
      end
      if (state_q != ST_REFILL) begin
        lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ~^ lfsr_q[5]};   // XNOR taps, zero is legal
      end
      if (refill_start_o) begin
        fill_way_q <= WAYS'(1) << victim;                   // Victim frozen for the refill
      end
    end
  end

  assign refill_adr_o.tag = tag_i.adr.f.tag;
  assign refill_adr_o.idx = tag_i.adr.f.idx;
  assign fill_way_o       = fill_way_q;
  assign invalidate_o     = (state_q == ST_INVAL);

  // ----------------------------------------
  // Parcel
  // ----------------------------------------
  always_comb begin
    parcel_o = '0;
    case (state_q)
      ST_IDLE: begin
        parcel_o.valid = tag_i.valid & hit_i & ~flush_i;
        parcel_o.data  = line_i[offs];
      end
      ST_DELIVER: begin
        parcel_o.valid = tag_i.valid & ~flush_i;   // Gone if flushed during refill
        parcel_o.err   = fill_i.err;
        parcel_o.data  = fill_i.line[offs];
      end
      default: parcel_o = '0;
    endcase
  end

  // A fill done outside refill would never reach the CPU
  a_done_in_refill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_i.done |-> state_q == ST_REFILL);

endmodule

/* verilog/icache_biu_ctrl.sv */
// Bus refill controller, requests one line as a fixed burst and collects the beats
module icache_biu_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  start_i,   // From the front end FSM
  input  icache_pkg::line_adr_t adr_i,

  output icache_pkg::biu_req_t  biu_req_o,
  input  icache_pkg::biu_rsp_t  biu_rsp_i,

  output icache_pkg::fill_t     fill_o
);
  import icache_pkg::*;

  typedef enum logic [1:0] {
    B_IDLE,
    B_REQ,    // Strobe up, waiting for stb_ack
    B_BEAT    // Collecting the burst
  } bstate_e;

  bstate_e              state_q;
  logic [OFFS_BITS-1:0] beat_q;      // Next word slot
  logic                 err_q;       // Sticky over the burst
  logic                 done_q;
  line_adr_t            adr_q;
  line_t                buf_q;       // Line buffer
  logic                 last_beat;

  assign last_beat = (state_q == B_BEAT) && biu_rsp_i.ack &&
                     (beat_q == OFFS_BITS'(BURST_LEN - 1));

  // ----------------------------------------
  // Control
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= B_IDLE;
      beat_q  <= '0;
      err_q   <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= last_beat;               // Pulse after the final beat
      case (state_q)
        B_IDLE: begin
          if (start_i) begin
            state_q <= B_REQ;
            beat_q  <= '0;
            err_q   <= 1'b0;
          end
        end
        B_REQ: begin
          if (biu_rsp_i.stb_ack) begin
            state_q <= B_BEAT;
          end
        end
        B_BEAT: begin
          if (biu_rsp_i.ack) begin
            beat_q <= beat_q + 1'b1;
            err_q  <= err_q | biu_rsp_i.err;   // One bad beat spoils the line
            if (last_beat) begin
              state_q <= B_IDLE;
            end
          end
        end
        default: state_q <= B_IDLE;
      endcase
    end
  end

  // Address and line data
  always_ff @(posedge clk_i) begin
    if (state_q == B_IDLE && start_i) begin
      adr_q <= adr_i;
    end
    if (state_q == B_BEAT && biu_rsp_i.ack) begin
      buf_q[beat_q] <= biu_rsp_i.q;         // Ascending word order
    end
  end

  assign biu_req_o.stb = (state_q == B_REQ);
  assign biu_req_o.adr = adr_q;

  // Line and error stay put until the next start
  assign fill_o.done = done_q;
  assign fill_o.err  = err_q;
  assign fill_o.idx  = adr_q.idx;
  assign fill_o.tag  = adr_q.tag;
  assign fill_o.line = buf_q;

  // Bus must not send data ahead of taking the request
  a_no_early_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_rsp_i.ack |-> state_q == B_BEAT);

endmodule

/* verilog/icache_core.sv */
// Instruction cache top level, wires the request pipeline, arrays, controller and bus refill
module icache_core #(
  parameter int WAYS = 2   // 1, 2 or 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // CPU side
  input  logic                   mem_req_i,
  input  icache_pkg::fetch_adr_u mem_adr_i,
  input  logic                   mem_flush_i,     // Kill in-flight requests
  input  logic                   cache_flush_i,   // Invalidate all lines
  output logic                   mem_stall_o,
  output icache_pkg::parcel_t    parcel_o,

  // Bus side
  output icache_pkg::biu_req_t   biu_req_o,
  input  icache_pkg::biu_rsp_t   biu_rsp_i
);
  import icache_pkg::*;

  stage_t          setup;        // Address setup stage
  stage_t          tag_stage;    // Tag compare stage
  logic            hit;
  line_t           line;
  fill_t           fill;
  logic [WAYS-1:0] fill_way;
  logic            invalidate;
  logic            refill_start;
  line_adr_t       refill_adr;

  // ----------------------------------------
  // Request pipeline
  // ----------------------------------------
  icache_pipe pipe_inst (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .req_i   ( mem_req_i   ),
    .adr_i   ( mem_adr_i   ),
    .stall_i ( mem_stall_o ),
    .flush_i ( mem_flush_i ),
    .setup_o ( setup       ),
    .tag_o   ( tag_stage   )
  );

  // ----------------------------------------
  // Tag, valid and data arrays
  // ----------------------------------------
  icache_memory #(
    .WAYS ( WAYS )
  ) memory_inst (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .stall_i      ( mem_stall_o ),
    .setup_i      ( setup       ),
    .tag_i        ( tag_stage   ),
    .fill_i       ( fill        ),
    .fill_way_i   ( fill_way    ),
    .invalidate_i ( invalidate  ),
    .hit_o        ( hit         ),
    .line_o       ( line        )
  );

  // Front end FSM that owns stall
  icache_ctrl #(
    .WAYS ( WAYS )
  ) ctrl_inst (
    .clk_i          ( clk_i         ),
    .rst_ni         ( rst_ni        ),
    .flush_i        ( mem_flush_i   ),
    .cache_flush_i  ( cache_flush_i ),
    .tag_i          ( tag_stage     ),
    .hit_i          ( hit           ),
    .line_i         ( line          ),
    .fill_i         ( fill          ),
    .stall_o        ( mem_stall_o   ),
    .refill_start_o ( refill_start  ),
    .refill_adr_o   ( refill_adr    ),
    .fill_way_o     ( fill_way      ),
    .invalidate_o   ( invalidate    ),
    .parcel_o       ( parcel_o      )
  );

  // Line refill over the bus
  icache_biu_ctrl biu_ctrl_inst (
    .clk_i     ( clk_i        ),
    .rst_ni    ( rst_ni       ),
    .start_i   ( refill_start ),
    .adr_i     ( refill_adr   ),
    .biu_req_o ( biu_req_o    ),
    .biu_rsp_i ( biu_rsp_i    ),
    .fill_o    ( fill         )
  );

endmodule

/* bench/icache_tb_mem.sv */
// Bus memory model for the cache bench, answers line refills with address-derived words
module icache_tb_mem (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [1:0]           err_mode_i,   // 0 clean, 1 random errors, 2 every beat bad
  input  icache_pkg::biu_req_t req_i,
  output icache_pkg::biu_rsp_t rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  integer    seed;
  line_adr_t adr_q;   // Line being served

  // Each word mixes its whole address
  function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] adr);
    logic [XLEN-1:0] a;
    a = {adr[XLEN-1:BYTE_BITS], 2'b00};
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h0bad_c0de;
  endfunction

  // Step to the drive point of the next cycle and drop the strobes
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
    rsp_o = '0;
  endtask

  task automatic random_wait();
    int n;
    n = $random(seed) & 3;      // 0 to 3 idle cycles
    for (int i = 0; i < n; i++) begin
      next_cycle();
    end
  endtask

  function automatic logic beat_err();
    case (err_mode_i)
      2'd1:    return ($random(seed) & 7) == 0;   // About one beat in eight
      2'd2:    return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // ----------------------------------------
  // Burst responder
  // ----------------------------------------
  initial begin
    seed  = 32'hc2ce1c6c;
    rsp_o = '0;
    forever begin
      next_cycle();
      if (rst_ni && req_i.stb) begin
        adr_q = req_i.adr;
        random_wait();                 // Late request acknowledge
        rsp_o.stb_ack = 1'b1;
        next_cycle();
        for (int b = 0; b < BURST_LEN; b++) begin
          random_wait();               // Gaps between beats
          rsp_o.ack = 1'b1;
          rsp_o.err = beat_err();
          rsp_o.q   = word_at({adr_q, b[OFFS_BITS-1:0], 2'b00});   // Ascending words
          next_cycle();
        end
      end
    end
  end

endmodule

/* bench/icache_tb.sv */
// Cache bench top, drives random fetches and flushes and checks parcels against a model
module icache_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  localparam int WAYS     = 2;
  localparam int TIMEOUT  = 400;                  // Cycles allowed per wait
  localparam int LA_BITS  = XLEN - OFFS_BITS - BYTE_BITS;

  typedef struct packed {
    logic [XLEN-1:0] adr;
    logic [31:0]     cyc;    // Cycle of acceptance
  } exp_t;

  logic       clk_i;
  logic       rst_ni;
  logic       mem_req_i;
  fetch_adr_u mem_adr_i;
  logic       mem_flush_i;
  logic       cache_flush_i;
  logic       mem_stall_o;
  parcel_t    parcel_o;
  biu_req_t   biu_req;
  biu_rsp_t   biu_rsp;
  logic [1:0] err_mode;

  integer             seed;
  int                 errors;
  int                 tests_run;
  int                 tests_failed;
  int                 burst_cnt;     // Requests taken by the bus
  int                 parcel_cnt;
  logic [31:0]        cyc;
  bit                 check_lat;     // Demand two cycle latency
  logic               last_err;
  exp_t               exp_q[$];      // Accepted, not killed, in order
  bit                 line_err[int]; // Error of the latest burst per line
  logic [LA_BITS-1:0] cur_line;
  logic               cur_err;
  int                 beats;

  icache_core #(
    .WAYS ( WAYS )
  ) icache_core_inst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .mem_req_i     ( mem_req_i     ),
    .mem_adr_i     ( mem_adr_i     ),
    .mem_flush_i   ( mem_flush_i   ),
    .cache_flush_i ( cache_flush_i ),
    .mem_stall_o   ( mem_stall_o   ),
    .parcel_o      ( parcel_o      ),
    .biu_req_o     ( biu_req       ),
    .biu_rsp_i     ( biu_rsp       )
  );

  icache_tb_mem mem_inst (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .err_mode_i ( err_mode ),
    .req_i      ( biu_req  ),
    .rsp_o      ( biu_rsp  )
  );

  always #10 clk_i = ~clk_i;                 // 20 ns period
  always @(posedge clk_i) cyc <= cyc + 1;

  // Same mix as the bus memory model
  function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] adr);
    logic [XLEN-1:0] a;
    a = {adr[XLEN-1:BYTE_BITS], 2'b00};
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h0bad_c0de;
  endfunction

  function automatic int line_of(input logic [XLEN-1:0] adr);
    return int'(adr[XLEN-1:OFFS_BITS+BYTE_BITS]);
  endfunction

  function automatic logic [XLEN-1:0] make_adr(input int tag, input int idx, input int offs);
    fetch_adr_u a;
    a.raw    = '0;
    a.f.tag  = TAG_BITS'(tag);
    a.f.idx  = IDX_BITS'(idx);
    a.f.offs = OFFS_BITS'(offs);
    return a.raw;
  endfunction

  // Small pool of three tags over four sets
  function automatic logic [XLEN-1:0] random_adr();
    int tag;
    int idx;
    int offs;
    tag  = $unsigned($random(seed)) % 3;
    idx  = $unsigned($random(seed)) % 4;
    offs = $unsigned($random(seed)) % 4;
    return make_adr(tag, idx, offs);
  endfunction

  // ----------------------------------------
  // Reference model and parcel checks
  // ----------------------------------------
  always @(negedge clk_i) begin
    exp_t e;
    logic want_err;
    if (rst_ni) begin
      if (biu_req.stb && biu_rsp.stb_ack) begin   // New burst
        burst_cnt++;
        cur_line = biu_req.adr;
        cur_err  = 1'b0;
        beats    = 0;
      end
      if (biu_rsp.ack) begin
        cur_err = cur_err | biu_rsp.err;
        beats++;
        if (beats == BURST_LEN) line_err[int'(cur_line)] = cur_err;
      end
      if (parcel_o.valid) begin
        parcel_cnt++;
        last_err = parcel_o.err;
        assert (exp_q.size() != 0) else begin
          $display("Parcel at %0t with no request outstanding", $time);
          errors++;
        end
        if (exp_q.size() != 0) begin
          e        = exp_q.pop_front();
          want_err = line_err.exists(line_of(e.adr)) ? line_err[line_of(e.adr)] : 1'b0;
          assert (parcel_o.err == want_err) else begin
            $display("ERROR t=%0t parcel_o.err got %0b exp %0b", $time, parcel_o.err, want_err);
            errors++;
          end
          if (!want_err) begin                 // Bad lines carry no usable data
            assert (parcel_o.data == word_at(e.adr)) else begin
              $display("ERROR t=%0t parcel_o.data got %h exp %h", $time, parcel_o.data,
                       word_at(e.adr));
              errors++;
            end
          end
          if (check_lat) begin
            assert (cyc - e.cyc == 2) else begin
              $display("ERROR t=%0t parcel_o.valid latency got %0d exp 2", $time, cyc - e.cyc);
              errors++;
            end
          end
        end
      end
      if (mem_flush_i) begin
        exp_q.delete();                         // Everything in flight dies
      end else if (mem_req_i && !mem_stall_o) begin
        e.adr = mem_adr_i.raw;
        e.cyc = cyc;
        exp_q.push_back(e);
      end
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  task automatic tick();
    @(posedge clk_i);
    #2;
    mem_flush_i   = 1'b0;   // Flushes are single cycle
    cache_flush_i = 1'b0;
  endtask

  // Hold one request until accepted, with optional random kills
  task automatic send(input logic [XLEN-1:0] adr, input bit kill_en);
    int waited;
    bit taken;
    waited        = 0;
    taken         = 1'b0;
    mem_req_i     = 1'b1;
    mem_adr_i.raw = adr;
    while (!taken && waited < TIMEOUT) begin
      @(negedge clk_i);
      taken = !mem_stall_o && !mem_flush_i;
      tick();
      waited++;
      if (kill_en && (($random(seed) & 15) == 0)) mem_flush_i = 1'b1;
    end
    mem_req_i = 1'b0;
    assert (taken) else begin
      $display("Request to %h was not accepted within %0d cycles", adr, TIMEOUT);
      errors++;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || mem_stall_o) && waited < TIMEOUT) begin
      tick();
      waited++;
    end
    assert (exp_q.size() == 0 && !mem_stall_o) else begin
      $display("Cache still busy after %0d cycles, %0d parcels missing", TIMEOUT, exp_q.size());
      errors++;
    end
  endtask

  task automatic report(input string name, input int start);
    tests_run++;
    if (errors == start) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - start);
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int start;
    int bursts;
    int parcels;
    bit resident;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    mem_req_i     = 1'b0;
    mem_adr_i     = '0;
    mem_flush_i   = 1'b0;
    cache_flush_i = 1'b0;
    err_mode      = 2'd0;
    seed          = 32'hc2ce1c6c;
    cyc           = '0;
    check_lat     = 1'b0;
    last_err      = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    burst_cnt     = 0;
    parcel_cnt    = 0;
    cur_line      = '0;
    cur_err       = 1'b0;
    beats         = 0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    start    = errors;                           // Random traffic, kills and bus errors
    err_mode = 2'd1;
    for (int i = 0; i < 300; i++) send(random_adr(), 1'b1);
    drain();
    report("parcels", start);

    start    = errors;                           // Fill four lines, then stream hits
    err_mode = 2'd0;
    for (int l = 0; l < 4; l++) send(make_adr(5, 8 + l, 0), 1'b0);
    drain();
    bursts    = burst_cnt;
    check_lat = 1'b1;
    for (int l = 0; l < 4; l++) begin
      for (int w = 0; w < BURST_LEN; w++) send(make_adr(5, 8 + l, w), 1'b0);
    end
    drain();
    check_lat = 1'b0;
    assert (burst_cnt == bursts) else begin
      $display("ERROR t=%0t biu_req_o.stb bursts got %0d exp %0d", $time, burst_cnt, bursts);
      errors++;
    end
    report("hits", start);

    start    = errors;                           // Two tags sharing set 16
    resident = 1'b0;
    for (int r = 0; r < 10 && !resident; r++) begin
      bursts = burst_cnt;
      send(make_adr(7, 16, 1), 1'b0);
      drain();
      send(make_adr(9, 16, 2), 1'b0);
      drain();
      if (burst_cnt == bursts) resident = 1'b1;
    end
    assert (resident) else begin
      $display("Two lines of one set never stayed resident together");
      errors++;
    end
    report("two_ways", start);

    start    = errors;                           // Every beat bad, then a clean retry
    err_mode = 2'd2;
    send(make_adr(3, 20, 2), 1'b0);
    drain();
    assert (last_err == 1'b1) else begin
      $display("ERROR t=%0t parcel_o.err got %0b exp 1", $time, last_err);
      errors++;
    end
    err_mode = 2'd0;
    bursts   = burst_cnt;
    send(make_adr(3, 20, 2), 1'b0);
    drain();
    assert (burst_cnt == bursts + 1) else begin
      $display("ERROR t=%0t biu_req_o.stb bursts got %0d exp %0d", $time, burst_cnt,
               bursts + 1);
      errors++;
    end
    assert (last_err == 1'b0) else begin
      $display("ERROR t=%0t parcel_o.err got %0b exp 0", $time, last_err);
      errors++;
    end
    report("bus_error", start);

    start = errors;                              // Invalidate all, then kill in flight
    for (int l = 0; l < 2; l++) send(make_adr(1, 24 + l, 0), 1'b0);
    drain();
    cache_flush_i = 1'b1;
    tick();
    repeat (3) tick();                           // Let the invalidate cycle pass
    bursts = burst_cnt;
    for (int l = 0; l < 2; l++) send(make_adr(1, 24 + l, 3), 1'b0);
    drain();
    assert (burst_cnt == bursts + 2) else begin
      $display("ERROR t=%0t biu_req_o.stb bursts got %0d exp %0d", $time, burst_cnt,
               bursts + 2);
      errors++;
    end
    parcels = parcel_cnt;
    send(make_adr(1, 24, 1), 1'b0);
    send(make_adr(1, 25, 1), 1'b0);
    mem_flush_i = 1'b1;                          // Both requests still in the pipe
    tick();
    drain();
    assert (parcel_cnt == parcels) else begin
      $display("ERROR t=%0t parcel_o.valid count got %0d exp %0d", $time, parcel_cnt, parcels);
      errors++;
    end
    report("flushes", start);

    $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* icache_core.f */
verilog/icache_pkg.sv
verilog/icache_pipe.sv
verilog/icache_memory.sv
verilog/icache_ctrl.sv
verilog/icache_biu_ctrl.sv
verilog/icache_core.sv
bench/icache_tb_mem.sv
bench/icache_tb.sv

/* run.sh */
#!/bin/sh
# Build the cache bench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module icache_tb -f icache_core.f -o icache_sim
./obj_dir/icache_sim | tee sim.log

if grep -q '^STATUS: PASS$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
